// ==== compile.f ====
+incdir+.
nn_pkg.sv
delta_if.sv
error_fetcher.sv
error_propagator.sv
delta_router.sv
error_calculator.sv
tb_error_calculator.sv

// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --timing --assert -Wno-fatal
TOP       := tb_error_calculator
FILELIST  := compile.f
LOG       := sim.log
BIN       := obj_dir/$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BIN): $(FILELIST) nn_config.svh $(filter %.sv,$(shell cat $(FILELIST)))
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)

# The run may stop on $fatal, the log decides pass or fail
sim: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qxF '** PASS **' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// ==== tb_error_calculator.sv ====
`timescale 1ns/10ps
`include "nn_config.svh"

module tb_error_calculator;

    import nn_pkg::*;

    localparam int MAX_CYCLES = 2000;   // ~40 commands of up to 12 cycles, stalls, margin
    localparam int LAT_FETCH  = 4;      // Accept edge to first edge with delta_valid
    localparam int LAT_PROP   = 9;

    logic        clk;
    logic        rst_n;
    logic        cmd_valid;
    logic        cmd_ready;
    layer_t      layer;
    act_vec_t    y;
    z_vec_t      z;
    weight_mat_t w;
    logic        delta_valid;
    logic        delta_ready;
    delta_vec_t  delta;
    logic        error;

    int          seed;
    int          cycle = 0;
    delta_vec_t  fb_model;      // Reference copy of the feedback register
    logic        err_model;     // Reference sticky overflow

    error_calculator DUT (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the run did not complete", MAX_CYCLES);
            stop_on_failure();
        end
    end

    ///////////////////////////////////////////////////////////////////////////
    // Compare tasks
    ///////////////////////////////////////////////////////////////////////////

    task automatic stop_on_failure();
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic check_delta(input delta_vec_t got, input delta_vec_t exp, input string what);
        for (int n = 0; n < `NN_NEURONS; n++) begin
            if (got[n] !== exp[n]) begin
                $display("** Error @ %0t ns: %s, cell %0d is %0d, expected %0d",
                         $time, what, n, got[n], exp[n]);
                stop_on_failure();
            end
        end
    endtask

    task automatic check_error(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("** Error @ %0t ns: %s is %b, expected %b", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        if (got != exp) begin
            $display("** Error @ %0t ns: latency %0d cycles, expected %0d", $time, got, exp);
            stop_on_failure();
        end
    endtask

    ///////////////////////////////////////////////////////////////////////////
    // Reference model
    ///////////////////////////////////////////////////////////////////////////

    // Q4 hard sigmoid, clamp((z >>> 2) + 0.5, 0, 1.0)
    function automatic int hard_sig(input int zi);
        int a;
        a = (zi >>> 2) + 8;
        return (a < 0) ? 0 : (a > 16) ? 16 : a;
    endfunction

    task automatic predict_delta(input layer_t l, input act_vec_t yv, input z_vec_t zv,
                                 input weight_mat_t wv, output delta_vec_t exp_d);
        int      v;
        int      s;
        int      zi;
        z_t      zc;
        weight_t wc;
        delta_t  dc;
        for (int j = 0; j < `NN_NEURONS; j++) begin
            zc = zv[j];
            zi = zc;
            if (l == layer_t'(`NN_LAYERS - 1)) begin
                v = hard_sig(zi) - int'(yv[j]);
            end else begin
                s = 0;
                for (int i = 0; i < `NN_NEURONS; i++) begin
                    wc = wv[i][j];              // Transposed weights
                    dc = fb_model[i];
                    s += int'(wc) * int'(dc);
                end
                s = s >>> `NN_FRAC;
                v = (zi > -32 && zi < 32) ? (s * 4) >>> 4 : 0;   // Slope 1/4 or 0
            end
            if (v > 127 || v < -128)
                err_model = 1'b1;
            v = (v > 127) ? 127 : (v < -128) ? -128 : v;
            exp_d[j] = delta_t'(v);
        end
        fb_model = exp_d;
    endtask

    ///////////////////////////////////////////////////////////////////////////
    // Drivers
    ///////////////////////////////////////////////////////////////////////////

    task automatic apply_reset();
        rst_n <= 1'b0;
        repeat (4) @(posedge clk);
        rst_n     <= 1'b1;
        fb_model  = '0;
        err_model = 1'b0;
        @(posedge clk);
    endtask

    task automatic random_operands(output act_vec_t yv, output z_vec_t zv,
                                   output weight_mat_t wv);
        for (int n = 0; n < `NN_NEURONS; n++) begin
            yv[n] = act_t'({$random(seed)} % 17);
            zv[n] = z_t'($random(seed) % 80);     // Both sides of |z| = 2.0
            for (int j = 0; j < `NN_NEURONS; j++)
                wv[n][j] = weight_t'($random(seed));
        end
    endtask

    task automatic send_cmd(input layer_t l, input act_vec_t yv, input z_vec_t zv,
                            input weight_mat_t wv, output int accepted_at);
        cmd_valid <= 1'b1;
        layer     <= l;
        y         <= yv;
        z         <= zv;
        w         <= wv;
        @(posedge clk);
        while (!cmd_ready)
            @(posedge clk);
        accepted_at = cycle;
        cmd_valid <= 1'b0;
    endtask

    // Holds delta_ready low for stall edges once the result shows up
    task automatic take_delta(input int stall, output delta_vec_t got, output int seen_at);
        delta_vec_t first;
        int         held;
        held = 0;
        delta_ready <= (stall == 0);
        @(posedge clk);
        while (!delta_valid)
            @(posedge clk);
        seen_at = cycle;
        first   = delta;
        while (held < stall) begin
            held++;
            if (held == stall)
                delta_ready <= 1'b1;
            @(posedge clk);
            if (!delta_valid) begin
                $display("delta_valid dropped while delta_ready was low");
                stop_on_failure();
            end
            check_delta(delta, first, "stalled output");
        end
        got = delta;                            // Transfer on this edge
        @(posedge clk);
        if (delta_valid) begin
            $display("The same result was presented again after its transfer");
            stop_on_failure();
        end
        if (!cmd_ready) begin
            $display("cmd_ready did not return one cycle after the delta transfer");
            stop_on_failure();
        end
    endtask

    task automatic run_cmd(input layer_t l, input act_vec_t yv, input z_vec_t zv,
                           input weight_mat_t wv, input int stall, output delta_vec_t got);
        int         acc_at;
        int         seen_at;
        delta_vec_t exp_d;
        send_cmd(l, yv, zv, wv, acc_at);
        take_delta(stall, got, seen_at);
        predict_delta(l, yv, zv, wv, exp_d);
        check_delta(got, exp_d, "delta against model");
        check_latency(seen_at - acc_at,
                      (l == layer_t'(`NN_LAYERS - 1)) ? LAT_FETCH : LAT_PROP);
        check_error(error, err_model, "sticky error");
    endtask

    ///////////////////////////////////////////////////////////////////////////
    // Directed tests
    ///////////////////////////////////////////////////////////////////////////

    task automatic idle_after_reset();
        act_vec_t    yv;
        z_vec_t      zv;
        weight_mat_t wv;
        delta_vec_t  got;
        if (!cmd_ready || delta_valid) begin
            $display("After reset cmd_ready must be high and delta_valid low");
            stop_on_failure();
        end
        check_error(error, 1'b0, "error after reset");
        random_operands(yv, zv, wv);
        run_cmd(layer_t'(0), yv, zv, wv, 0, got);
        check_delta(got, '0, "layer 0 with empty feedback");
    endtask

    task automatic output_layer_deltas();
        act_vec_t    yv;
        z_vec_t      zv;
        delta_vec_t  exp_d;
        delta_vec_t  got;
        zv[0] = z_t'(-100);     // Clamps at 0
        yv[0] = act_t'(4);
        zv[1] = z_t'(100);      // Clamps at 16
        yv[1] = act_t'(3);
        zv[2] = z_t'(12);
        yv[2] = act_t'(8);
        zv[3] = z_t'(-13);      // Shift rounds toward minus infinity
        yv[3] = act_t'(10);
        exp_d[0] = delta_t'(-4);
        exp_d[1] = delta_t'(13);
        exp_d[2] = delta_t'(3);
        exp_d[3] = delta_t'(-6);
        run_cmd(layer_t'(`NN_LAYERS - 1), yv, zv, '0, 0, got);
        check_delta(got, exp_d, "hard sigmoid minus target");
    endtask

    // Uses the feedback left by output_layer_deltas
    task automatic lower_layer_gating();
        z_vec_t      zv;
        weight_mat_t wv;
        delta_vec_t  exp_d;
        delta_vec_t  got;
        for (int i = 0; i < `NN_NEURONS; i++)
            for (int j = 0; j < `NN_NEURONS; j++)
                wv[i][j] = weight_t'(32);       // 2.0 everywhere
        zv[0] = z_t'(0);
        zv[1] = z_t'(40);
        zv[2] = z_t'(-32);                      // Edge of the slope region
        zv[3] = z_t'(31);
        exp_d[0] = delta_t'(3);
        exp_d[1] = delta_t'(0);
        exp_d[2] = delta_t'(0);
        exp_d[3] = delta_t'(3);
        run_cmd(layer_t'(1), '0, zv, wv, 0, got);
        check_delta(got, exp_d, "propagated delta");
    endtask

    task automatic layer_chain();
        act_vec_t    yv;
        z_vec_t      zv;
        weight_mat_t wv;
        delta_vec_t  got;
        for (int k = 0; k < 6; k++) begin
            for (int l = `NN_LAYERS - 1; l >= 0; l--) begin
                random_operands(yv, zv, wv);
                run_cmd(layer_t'(l), yv, zv, wv, 0, got);
            end
        end
    endtask

    task automatic backpressure();
        act_vec_t    yv;
        z_vec_t      zv;
        weight_mat_t wv;
        delta_vec_t  got;
        for (int k = 0; k < 8; k++) begin
            random_operands(yv, zv, wv);
            run_cmd(layer_t'({$random(seed)} % 3), yv, zv, wv, {$random(seed)} % 6, got);
        end
    endtask

    task automatic saturation();
        act_vec_t    yv;
        z_vec_t      zv;
        weight_mat_t wv;
        delta_vec_t  exp_d;
        delta_vec_t  got;
        apply_reset();
        check_error(error, 1'b0, "error after second reset");
        for (int n = 0; n < `NN_NEURONS; n++) begin
            zv[n] = z_t'(100);
            yv[n] = act_t'((n % 2 == 0) ? 144 : 0);     // 16 - 144 lands on -128
            exp_d[n] = delta_t'((n % 2 == 0) ? -128 : 16);
            for (int i = 0; i < `NN_NEURONS; i++)
                wv[i][n] = weight_t'((n == 0) ? 127 : (n == 1) ? -128 : 1);
        end
        run_cmd(layer_t'(`NN_LAYERS - 1), yv, zv, '0, 0, got);
        check_delta(got, exp_d, "fetcher delta at -128");
        check_error(error, 1'b0, "error without a clip");
        exp_d[0] = delta_t'(-128);
        exp_d[1] = delta_t'(127);
        exp_d[2] = delta_t'(-4);
        exp_d[3] = delta_t'(-4);
        run_cmd(layer_t'(1), '0, '0, wv, 0, got);
        check_delta(got, exp_d, "propagator clip");
        check_error(error, 1'b1, "error after propagator clip");
        // In-range commands leave the flag set
        run_cmd(layer_t'(`NN_LAYERS - 1), {`NN_NEURONS{act_t'(8)}}, '0, '0, 0, got);
        run_cmd(layer_t'(0), '0, '0, '0, 0, got);
        check_error(error, 1'b1, "error after in-range commands");
        // Fetcher clip on its own
        apply_reset();
        check_error(error, 1'b0, "error after third reset");
        run_cmd(layer_t'(`NN_LAYERS - 1), {`NN_NEURONS{act_t'(300)}}, zv, '0, 0, got);
        check_delta(got, {`NN_NEURONS{delta_t'(-128)}}, "fetcher clip to -128");
        check_error(error, 1'b1, "error after fetcher clip");
    endtask

    initial begin
        seed        = 86;
        clk         = 1'b0;
        rst_n       = 1'b0;
        cmd_valid   = 1'b0;
        layer       = '0;
        y           = '0;
        z           = '0;
        w           = '0;
        delta_ready = 1'b1;
        fb_model    = '0;
        err_model   = 1'b0;
        apply_reset();
        idle_after_reset();
        output_layer_deltas();
        lower_layer_gating();
        layer_chain();
        backpressure();
        saturation();
        $display("** PASS **");
        $finish;
    end

endmodule

// ==== error_calculator.sv ====
`timescale 1ns/10ps

module error_calculator (
    input  logic                clk,
    input  logic                rst_n,
    // Command
    input  logic                cmd_valid,
    output logic                cmd_ready,
    input  nn_pkg::layer_t      layer,
    input  nn_pkg::act_vec_t    y,
    input  nn_pkg::z_vec_t      z,
    input  nn_pkg::weight_mat_t w,
    // Result
    output logic                delta_valid,
    input  logic                delta_ready,
    output nn_pkg::delta_vec_t  delta,
    output logic                error           // Sticky overflow
);

    import nn_pkg::*;

    logic        fetch_valid, fetch_ready;
    z_vec_t      fetch_z;
    act_vec_t    fetch_y;
    logic        prop_valid, prop_ready;
    z_vec_t      prop_z;
    weight_mat_t prop_w;
    delta_vec_t  prop_delta;

    delta_if fetch_res ();
    delta_if prop_res ();

    ////////////////////////////////////////////////////////////////////////////
    // Instances
    ////////////////////////////////////////////////////////////////////////////

    delta_router router (
        .clk        (clk        ),
        .rst_n      (rst_n      ),
        .cmd_valid  (cmd_valid  ),
        .cmd_ready  (cmd_ready  ),
        .layer      (layer      ),
        .y          (y          ),
        .z          (z          ),
        .w          (w          ),
        .fetch_valid(fetch_valid),
        .fetch_ready(fetch_ready),
        .fetch_z    (fetch_z    ),
        .fetch_y    (fetch_y    ),
        .fetch_res  (fetch_res  ),
        .prop_valid (prop_valid ),
        .prop_ready (prop_ready ),
        .prop_z     (prop_z     ),
        .prop_w     (prop_w     ),
        .prop_delta (prop_delta ),
        .prop_res   (prop_res   ),
        .delta_valid(delta_valid),
        .delta_ready(delta_ready),
        .delta      (delta      ),
        .error      (error      )
    );

    error_fetcher fetcher (
        .clk     (clk        ),
        .rst_n   (rst_n      ),
        .in_valid(fetch_valid),
        .in_ready(fetch_ready),
        .z       (fetch_z    ),
        .y       (fetch_y    ),
        .res     (fetch_res  )
    );

    error_propagator propagator (
        .clk     (clk       ),
        .rst_n   (rst_n     ),
        .in_valid(prop_valid),
        .in_ready(prop_ready),
        .z       (prop_z    ),
        .w       (prop_w    ),
        .delta_in(prop_delta),
        .res     (prop_res  )
    );

endmodule

// ==== delta_router.sv ====
`timescale 1ns/10ps
`include "nn_config.svh"

module delta_router (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cmd_valid,
    output logic                 cmd_ready,
    input  nn_pkg::layer_t       layer,
    input  nn_pkg::act_vec_t     y,
    input  nn_pkg::z_vec_t       z,
    input  nn_pkg::weight_mat_t  w,
    output logic                 fetch_valid,
    input  logic                 fetch_ready,
    output nn_pkg::z_vec_t       fetch_z,
    output nn_pkg::act_vec_t     fetch_y,
    delta_if.snk                 fetch_res,
    output logic                 prop_valid,
    input  logic                 prop_ready,
    output nn_pkg::z_vec_t       prop_z,
    output nn_pkg::weight_mat_t  prop_w,
    output nn_pkg::delta_vec_t   prop_delta,
    delta_if.snk                 prop_res,
    output logic                 delta_valid,
    input  logic                 delta_ready,
    output nn_pkg::delta_vec_t   delta,
    output logic                 error
);

    import nn_pkg::*;

    route_state_t state;
    logic         issued;   // Operands handed to the part
    act_vec_t     y_q;
    z_vec_t       z_q;
    weight_mat_t  w_q;
    delta_vec_t   fb_q;     // Last result, next propagation input

    assign cmd_ready   = (state == R_IDLE);
    assign fetch_valid = (state == R_FETCH) && !issued;
    assign prop_valid  = (state == R_PROP) && !issued;
    assign fetch_res.ready = (state == R_FETCH) && issued;
    assign prop_res.ready  = (state == R_PROP) && issued;

    assign fetch_z    = z_q;
    assign fetch_y    = y_q;
    assign prop_z     = z_q;
    assign prop_w     = w_q;
    assign prop_delta = fb_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= R_IDLE;
            issued      <= 1'b0;
            fb_q        <= '0;
            delta_valid <= 1'b0;
            error       <= 1'b0;
        end else begin
            case (state)
                R_IDLE: begin
                    if (cmd_valid) begin
                        issued <= 1'b0;
                        state  <= (layer == layer_t'(`NN_LAYERS - 1)) ? R_FETCH : R_PROP;
                    end
                end
                R_FETCH: begin
                    if (fetch_valid && fetch_ready)
                        issued <= 1'b1;
                    if (fetch_res.valid && fetch_res.ready) begin
                        fb_q  <= fetch_res.delta;
                        error <= error | fetch_res.ovf;
                        state <= R_OUT;
                    end
                end
                R_PROP: begin
                    if (prop_valid && prop_ready)
                        issued <= 1'b1;
                    if (prop_res.valid && prop_res.ready) begin
                        fb_q  <= prop_res.delta;
                        error <= error | prop_res.ovf;  // Sticky
                        state <= R_OUT;
                    end
                end
                R_OUT: begin
                    if (!delta_valid) begin
                        delta_valid <= 1'b1;
                    end else if (delta_ready) begin
                        delta_valid <= 1'b0;
                        state       <= R_IDLE;
                    end
                end
                default: state <= R_IDLE;
            endcase
        end
    end

    // Command operands and output register
    always_ff @(posedge clk) begin
        if (state == R_IDLE && cmd_valid) begin
            y_q <= y;
            z_q <= z;
            w_q <= w;
        end
        if (state == R_OUT && !delta_valid)
            delta <= fb_q;
    end

    // Only the part in use may hold a result
    a_one_part: assert property (@(posedge clk) disable iff (!rst_n)
        !(fetch_res.valid && state != R_FETCH) && !(prop_res.valid && state != R_PROP));

endmodule

// ==== error_propagator.sv ====
`timescale 1ns/10ps
`include "nn_config.svh"

module error_propagator (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    output logic                in_ready,
    input  nn_pkg::z_vec_t      z,
    input  nn_pkg::weight_mat_t w,
    input  nn_pkg::delta_vec_t  delta_in,
    delta_if.src                res
);

    import nn_pkg::*;

    localparam int ROW_W = $clog2(`NN_NEURONS);
    localparam int ACC_W = `NN_WEIGHT_W + `NN_DELTA_W + ROW_W;  // Sum of four products

    prop_state_t state;
    logic [ROW_W-1:0] row;              // Row i being accumulated

    // Latched operands
    z_vec_t      z_q;
    weight_mat_t w_q;
    delta_vec_t  d_q;

    logic signed [ACC_W-1:0]   acc    [`NN_NEURONS];
    logic signed [ACC_W-1:0]   s_sh   [`NN_NEURONS];
    logic signed [4:0]         deriv  [`NN_NEURONS];
    logic signed [ACC_W+4:0]   t_full [`NN_NEURONS];
    delta_vec_t                t_sat;
    logic [`NN_NEURONS-1:0]    clip;

    assign in_ready = (state == P_IDLE);

    ////////////////////////////////////////////////////////////////////////////
    // Scaling and derivative
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int j = 0; j < `NN_NEURONS; j++) begin
            s_sh[j] = acc[j] >>> `NN_FRAC;
            // Slope of the hard sigmoid is 1/4 inside |z| < 2.0
            deriv[j]  = (z_q[j] > -32 && z_q[j] < 32) ? 5'sd4 : 5'sd0;
            t_full[j] = (s_sh[j] * deriv[j]) >>> `NN_FRAC;
            t_sat[j]  = sat_delta(t_full[j]);
            clip[j]   = is_clipped(t_full[j]);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Control FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= P_IDLE;
            row       <= '0;
            res.valid <= 1'b0;
        end else begin
            case (state)
                P_IDLE: begin
                    if (in_valid) begin
                        state <= P_ACC;
                        row   <= '0;
                    end
                end
                P_ACC: begin
                    row <= row + 1'b1;
                    if (row == ROW_W'(`NN_NEURONS - 1))
                        state <= P_SCALE;   // Last row this cycle
                end
                P_SCALE: begin
                    state     <= P_OUT;
                    res.valid <= 1'b1;
                end
                P_OUT: begin
                    // Hold until the router takes it
                    if (res.ready) begin
                        state     <= P_IDLE;
                        res.valid <= 1'b0;
                    end
                end
                default: state <= P_IDLE;
            endcase
        end
    end

    // Datapath
    always_ff @(posedge clk) begin
        case (state)
            P_IDLE: begin
                if (in_valid) begin
                    z_q <= z;
                    w_q <= w;
                    d_q <= delta_in;
                    for (int j = 0; j < `NN_NEURONS; j++)
                        acc[j] <= '0;
                end
            end
            P_ACC: begin
                // Transposed product, row i feeds every column j
                for (int j = 0; j < `NN_NEURONS; j++)
                    acc[j] <= acc[j] + w_q[row][j] * d_q[row];
            end
            P_SCALE: begin
                res.delta <= t_sat;
                res.ovf   <= |clip;
            end
            default: ;
        endcase
    end

    // Result six cycles after accept
    a_res_latency: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(res.valid) |-> $past(in_valid && in_ready, 6));

endmodule

// ==== error_fetcher.sv ====
`timescale 1ns/10ps
`include "nn_config.svh"

module error_fetcher (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    output logic             in_ready,
    input  nn_pkg::z_vec_t   z,
    input  nn_pkg::act_vec_t y,
    delta_if.src             res
);

    import nn_pkg::*;

    logic        [`NN_FRAC:0]   act  [`NN_NEURONS];
    logic signed [`NN_ACT_W+1:0] diff [`NN_NEURONS];
    delta_vec_t                 delta_d;
    logic [`NN_NEURONS-1:0]     clip_d;

    // a = clamp((z >>> 2) + 0.5, 0, 1.0) in Q4
    function automatic logic [`NN_FRAC:0] hard_sigmoid(input z_t zc);
        logic signed [`NN_Z_W-1:0] v;
        v = (zc >>> 2) + 8;
        if (v < 0)
            return '0;
        else if (v > (1 << `NN_FRAC))
            return (1 << `NN_FRAC);
        else
            return v[`NN_FRAC:0];
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Per-cell error
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int n = 0; n < `NN_NEURONS; n++) begin
            act[n]     = hard_sigmoid(z[n]);
            diff[n]    = $signed({1'b0, act[n]}) - $signed({1'b0, y[n]});
            delta_d[n] = sat_delta(diff[n]);
            clip_d[n]  = is_clipped(diff[n]);
        end
    end

    // Output register empty or draining this cycle
    assign in_ready = !res.valid || res.ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res.valid <= 1'b0;
        end else if (in_valid && in_ready) begin
            res.valid <= 1'b1;
        end else if (res.ready) begin
            res.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            res.delta <= delta_d;
            res.ovf   <= |clip_d;   // Any clipped cell
        end
    end

    // Stalled result must not move
    a_res_hold: assert property (@(posedge clk) disable iff (!rst_n)
        res.valid && !res.ready |=> res.valid && $stable(res.delta));

endmodule

// ==== delta_if.sv ====
`timescale 1ns/10ps

// Result channel from a delta unit back to the router
interface delta_if;

    import nn_pkg::*;

    delta_vec_t delta;
    logic       valid;
    logic       ready;
    logic       ovf;    // Some cell of delta was clipped

    // Producer side
    modport src (
        output delta,
        output valid,
        output ovf,
        input  ready
    );

    // Consumer side
    modport snk (
        input  delta,
        input  valid,
        input  ovf,
        output ready
    );

endinterface

// ==== nn_pkg.sv ====
package nn_pkg;

    `include "nn_config.svh"

    // Scalar cells
    typedef logic signed [`NN_DELTA_W-1:0]  delta_t;
    typedef logic signed [`NN_WEIGHT_W-1:0] weight_t;
    typedef logic signed [`NN_Z_W-1:0]      z_t;
    typedef logic        [`NN_ACT_W-1:0]    act_t;   // Unsigned target
    typedef logic        [`NN_LAYER_W-1:0]  layer_t;

    // Vectors, one cell per neuron
    typedef delta_t [`NN_NEURONS-1:0] delta_vec_t;
    typedef z_t     [`NN_NEURONS-1:0] z_vec_t;
    typedef act_t   [`NN_NEURONS-1:0] act_vec_t;
    typedef weight_t [`NN_NEURONS-1:0][`NN_NEURONS-1:0] weight_mat_t;  // [i][j]

    typedef enum logic [1:0] {P_IDLE, P_ACC, P_SCALE, P_OUT} prop_state_t;
    typedef enum logic [1:0] {R_IDLE, R_FETCH, R_PROP, R_OUT} route_state_t;

    localparam int DELTA_MAX = 2 ** (`NN_DELTA_W - 1) - 1;
    localparam int DELTA_MIN = -(2 ** (`NN_DELTA_W - 1));

    // Clip to the delta cell range
    function automatic delta_t sat_delta(input int v);
        if (v > DELTA_MAX)
            return delta_t'(DELTA_MAX);
        else if (v < DELTA_MIN)
            return delta_t'(DELTA_MIN);
        else
            return delta_t'(v);
    endfunction

    function automatic logic is_clipped(input int v);
        return (v > DELTA_MAX) || (v < DELTA_MIN);
    endfunction

endpackage

// ==== nn_config.svh ====
`ifndef NN_CONFIG_SVH
`define NN_CONFIG_SVH

// Network shape
`define NN_NEURONS  4
`define NN_LAYERS   3
`define NN_LAYER_W  2   // Wide enough for NN_LAYERS-1

// Cell widths
`define NN_Z_W      10  // Signed pre-activation
`define NN_ACT_W    9   // Unsigned target
`define NN_DELTA_W  8
`define NN_WEIGHT_W 8

// All cells are Q4
`define NN_FRAC     4

`endif
